// ==== rob_core.f ====
+incdir+.
rob_pkg.sv
rob_queue.sv
rob_issue_select.sv
rob_commit.sv
rob_core.sv
rob_checker.sv
tb_rob_core.sv

// ==== Makefile ====
VERILATOR  ?= verilator
SIM_FLAGS  ?= --binary --timing -j 0
LINT_FLAGS ?= --lint-only --timing
TOP        ?= tb_rob_core
FILELIST   ?= rob_core.f
OBJ_DIR    ?= obj_dir
PASS_MSG   := PASS: all tests

.PHONY: lint sim clean

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) | tee /dev/stderr | grep -q "^$(PASS_MSG)$$"

clean:
	rm -rf $(OBJ_DIR)

// ==== rob_core_stim.txt ====
# D op arch pdst src1 src2 | W idx exc | S mask | R alu lsu bru | F | N cycles
# C arch pdst | I unit idx | M room | X exc ; op 0 alu 1 ld 2 st 3 br ; unit 0 alu 1 lsu 2 bru
# out-of-order writebacks, in-order dual retire
I 0 0
I 0 1
I 0 2
I 0 3
C 1 8
C 2 9
C 3 10
C 4 11
D 0 1 8 1 2
D 0 2 9 1 2
D 0 3 10 1 2
D 0 4 11 1 2
N 3
W 3 0
W 1 0
W 2 0
W 0 0
N 4
# scoreboard hold, younger ready entry goes first
I 0 5
I 0 4
C 5 12
C 6 14
S 00ff
D 0 5 12 13 0
D 0 6 14 3 4
N 4
S ffff
N 3
W 5 0
W 4 0
N 4
# branch unit held low
I 2 6
I 2 7
C 7 15
C 0 1
R 1 1 0
D 3 7 15 1 2
D 3 0 1 2 3
N 4
R 1 1 1
N 4
W 7 0
W 6 0
N 4
# store waits for the head, load passes it
I 1 2
I 0 0
I 1 1
C 1 4
C 2 5
C 3 6
S 00ff
D 0 1 4 13 0
D 2 2 5 1 2
D 1 3 6 1 2
N 4
S ffff
N 3
W 0 0
W 2 0
N 4
W 1 0
N 4
# exception at head stops retirement until flush
I 0 3
I 0 4
D 0 4 7 1 2
D 0 5 8 1 2
N 3
W 3 1
N 3
X 1
W 4 0
N 3
X 1
F
N 1
X 0
# refill from slot 0, room, then wrap past 7
I 0 0
I 0 1
I 0 2
I 0 3
I 0 4
I 0 5
I 0 6
C 1 9
C 2 10
C 3 11
C 4 12
C 5 13
C 6 14
C 7 15
D 0 1 9 1 2
D 0 2 10 1 2
D 0 3 11 1 2
D 0 4 12 1 2
D 0 5 13 1 2
D 0 6 14 1 2
M 1
D 0 7 15 1 2
M 0
N 2
W 0 0
W 1 0
W 2 0
W 3 0
W 4 0
W 5 0
W 6 0
N 3
M 1
I 0 7
I 0 0
I 0 1
C 0 3
C 1 4
C 2 5
D 0 0 3 1 2
D 0 1 4 1 2
D 0 2 5 1 2
N 3
W 1 0
W 0 0
W 7 0
N 4

// ==== tb_rob_core.sv ====
`timescale 1ns/1ps
`include "rob_defs.svh"

module tb_rob_core;
    import rob_pkg::*;

    localparam int CLK_PERIOD = 4;

    logic clk_in;
    logic rst_N_in;
    logic flush_in;
    rob_entry_t [`DISPATCH_WIDTH-1:0] dispatch_in;
    rob_wb_t [`WB_PORTS-1:0]          wb_in;
    logic [`NUM_PHYS_REGS-1:0]        scoreboard_in;
    logic alu_ready_in;
    logic lsu_ready_in;
    logic bru_ready_in;
    logic room;
    logic exception_out;
    rob_issue_t alu_issue;
    rob_issue_t lsu_issue;
    rob_issue_t bru_issue;
    rob_commit_t [1:0] commit_out;
    logic [1:0] level_sel;
    logic       level_exp;

    string lines[$];
    int    n_lines = 0;
    int    bad_lines = 0;
    int    alloc_idx = 0; // slot the next dispatch lands in

    rob_core dut (
        .clk_in(clk_in), .rst_N_in(rst_N_in), .flush_in(flush_in),
        .dispatch_in(dispatch_in), .wb_in(wb_in), .scoreboard_in(scoreboard_in),
        .alu_ready_in(alu_ready_in), .lsu_ready_in(lsu_ready_in),
        .bru_ready_in(bru_ready_in), .room(room), .alu_issue(alu_issue),
        .lsu_issue(lsu_issue), .bru_issue(bru_issue), .commit_out(commit_out),
        .exception_out(exception_out)
    );

    rob_checker chk (
        .clk_in(clk_in), .rst_N_in(rst_N_in), .alu_issue(alu_issue),
        .lsu_issue(lsu_issue), .bru_issue(bru_issue), .commit_out(commit_out),
        .room(room), .exception_out(exception_out), .alu_ready(alu_ready_in),
        .lsu_ready(lsu_ready_in), .bru_ready(bru_ready_in), .level_sel(level_sel),
        .level_exp(level_exp)
    );

    initial begin
        clk_in = 1'b0;
        forever #(CLK_PERIOD / 2) clk_in = ~clk_in;
    end

    initial begin
        wait (n_lines != 0);
        #(longint'(n_lines + 10) * 20 * CLK_PERIOD);
        $display("timeout: stim sequence did not finish in time");
        $display("FAIL: see errors above");
        $finish;
    end

    function automatic rob_entry_t make_entry(input int op, input int arch, input int pdst,
                                              input int s1, input int s2);
        rob_entry_t e;
        e           = '0;
        e.valid     = 1'b1;
        e.op        = rob_op_e'(op[1:0]);
        e.arch_dest = arch[2:0];
        e.phys_dest = pdst[3:0];
        e.phys_src1 = s1[3:0];
        e.phys_src2 = s2[3:0];
        return e;
    endfunction

    // one clock, strobes drop back to idle unless the caller sets them again
    task automatic step();
        @(posedge clk_in);
        dispatch_in <= '0;
        wb_in       <= '0;
        flush_in    <= 1'b0;
        level_sel   <= 2'd0;
    endtask

    task automatic run_line(input string line);
        string cmd;
        int    a, b, c, d, e;
        logic [`NUM_PHYS_REGS-1:0] mask;
        rob_entry_t ent;
        a = 0;
        b = 0;
        c = 0;
        d = 0;
        e = 0;
        mask = '0;
        void'($sscanf(line, "%s %d %d %d %d %d", cmd, a, b, c, d, e));
        case (cmd)
            "D": begin
                ent = make_entry(a, b, c, d, e);
                step();
                dispatch_in[0] <= ent;
                chk.note_dispatch(alloc_idx, ent);
                alloc_idx = (alloc_idx + 1) % `ROB_ENTRIES; // window is circular
            end
            "W": begin
                step();
                wb_in[0] <= '{valid: 1'b1, ptr: a[2:0], exception: b[0]};
            end
            "S": begin
                void'($sscanf(line, "%s %h", cmd, mask));
                step();
                scoreboard_in <= mask;
            end
            "R": begin
                step();
                alu_ready_in <= a[0];
                lsu_ready_in <= b[0];
                bru_ready_in <= c[0];
            end
            "F": begin
                step();
                flush_in <= 1'b1;
                alloc_idx = 0;
            end
            "N": repeat (a) step();
            "C": chk.add_commit(a, b);
            "I": chk.add_issue(a, b);
            "M", "X": begin
                step();
                level_sel <= (cmd == "M") ? 2'd1 : 2'd2;
                level_exp <= a[0];
            end
            default: begin
                $display("stim line not understood: %s", line);
                bad_lines++;
            end
        endcase
    endtask

    initial begin
        int    fd;
        int    errs;
        string line;
        rst_N_in      = 1'b1;
        flush_in      = 1'b0;
        dispatch_in   = '0;
        wb_in         = '0;
        scoreboard_in = '1;
        alu_ready_in  = 1'b1;
        lsu_ready_in  = 1'b1;
        bru_ready_in  = 1'b1;
        level_sel     = 2'd0;
        level_exp     = 1'b0;

        fd = $fopen("rob_core_stim.txt", "r");
        if (fd == 0) begin
            $display("could not open rob_core_stim.txt");
            $display("FAIL: see errors above");
            $finish;
        end else begin
            while (!$feof(fd)) begin
                line = "";
                void'($fgets(line, fd));
                if (line.len() > 1 && line[0] != "#")
                    lines.push_back(line);
            end
            $fclose(fd);
            n_lines = lines.size();

            repeat (10) @(posedge clk_in);
            rst_N_in <= 1'b0;
            foreach (lines[i])
                run_line(lines[i]);
            repeat (10) step();

            errs = chk.report();
            if (errs == 0 && bad_lines == 0) begin
                $display("PASS: all tests");
            end else begin
                $display("FAIL: see errors above");
            end
            $finish;
        end
    end

endmodule

// ==== rob_checker.sv ====
`timescale 1ns/1ps
`include "rob_defs.svh"

module rob_checker (
    input  logic                       clk_in,
    input  logic                       rst_N_in,
    input  rob_pkg::rob_issue_t        alu_issue,
    input  rob_pkg::rob_issue_t        lsu_issue,
    input  rob_pkg::rob_issue_t        bru_issue,
    input  rob_pkg::rob_commit_t [1:0] commit_out,
    input  logic                       room,
    input  logic                       exception_out,
    input  logic                       alu_ready,
    input  logic                       lsu_ready,
    input  logic                       bru_ready,
    input  logic [1:0]                 level_sel,  // 1 room, 2 exception level
    input  logic                       level_exp
);
    import rob_pkg::*;

    logic [6:0] exp_commit[$]; // {arch_dest, phys_dest}
    int exp_alu[$];
    int exp_lsu[$];
    int exp_bru[$];
    rob_entry_t slot_exp[`ROB_ENTRIES]; // micro-op last dispatched into each slot
    logic alu_ready_q, lsu_ready_q, bru_ready_q; // levels the last edge's picks saw
    int mismatches = 0;
    int unexpected = 0;

    function void add_commit(input int arch, input int phys);
        exp_commit.push_back({arch[2:0], phys[3:0]});
    endfunction

    function void add_issue(input int unit, input int idx);
        case (unit)
            0:       exp_alu.push_back(idx);
            1:       exp_lsu.push_back(idx);
            default: exp_bru.push_back(idx);
        endcase
    endfunction

    function void note_dispatch(input int idx, input rob_entry_t e);
        slot_exp[idx] = e;
    endfunction

    function void compare_issue(input string unit, input int got, input int expv);
        if (got != expv) begin
            $display("FAIL @%0t: %s issued slot %0d, expected slot %0d", $time, unit, got, expv);
            mismatches++;
        end
    endfunction

    function void stray_issue(input string unit, input int got);
        $display("FAIL @%0t: %s issued slot %0d with nothing expected", $time, unit, got);
        unexpected++;
    endfunction

    // a held unit gets nothing, and the payload is the micro-op dispatched to that slot
    function void check_issue_fields(input string unit, input rob_issue_t got, input logic free);
        rob_entry_t e;
        e = slot_exp[got.ptr];
        if (!free) begin
            $display("FAIL @%0t: %s issued slot %0d while its ready level was low",
                     $time, unit, got.ptr);
            mismatches++;
        end
        if (got.op != e.op || got.phys_dest != e.phys_dest
            || got.phys_src1 != e.phys_src1 || got.phys_src2 != e.phys_src2) begin
            $display("FAIL @%0t: %s issued slot %0d with the wrong micro-op fields",
                     $time, unit, got.ptr);
            mismatches++;
        end
    endfunction

    always @(posedge clk_in) begin
        alu_ready_q <= alu_ready;
        lsu_ready_q <= lsu_ready;
        bru_ready_q <= bru_ready;
    end

    // outputs settle after the rising edge, so look at them mid-cycle
    always @(negedge clk_in) begin
        if (!rst_N_in) begin
            for (int k = 0; k < 2; k++) begin
                if (commit_out[k].valid) begin
                    if (exp_commit.size() == 0) begin
                        $display("FAIL @%0t: commit arch %0d phys %0d with nothing expected",
                                 $time, commit_out[k].arch_dest, commit_out[k].phys_dest);
                        unexpected++;
                    end else if ({commit_out[k].arch_dest, commit_out[k].phys_dest}
                                 != exp_commit[0]) begin
                        $display("FAIL @%0t: commit arch %0d phys %0d, expected arch %0d phys %0d",
                                 $time, commit_out[k].arch_dest, commit_out[k].phys_dest,
                                 exp_commit[0][6:4], exp_commit[0][3:0]);
                        mismatches++;
                        void'(exp_commit.pop_front());
                    end else begin
                        void'(exp_commit.pop_front());
                    end
                end
            end
            if (commit_out[1].valid && !commit_out[0].valid) begin
                $display("FAIL @%0t: second commit lane valid without the first", $time);
                mismatches++;
            end

            if (alu_issue.valid) begin
                check_issue_fields("alu", alu_issue, alu_ready_q);
                if (exp_alu.size() == 0)
                    stray_issue("alu", alu_issue.ptr);
                else
                    compare_issue("alu", alu_issue.ptr, exp_alu.pop_front());
            end
            if (lsu_issue.valid) begin
                check_issue_fields("lsu", lsu_issue, lsu_ready_q);
                if (exp_lsu.size() == 0)
                    stray_issue("lsu", lsu_issue.ptr);
                else
                    compare_issue("lsu", lsu_issue.ptr, exp_lsu.pop_front());
            end
            if (bru_issue.valid) begin
                check_issue_fields("bru", bru_issue, bru_ready_q);
                if (exp_bru.size() == 0)
                    stray_issue("bru", bru_issue.ptr);
                else
                    compare_issue("bru", bru_issue.ptr, exp_bru.pop_front());
            end

            if (level_sel == 2'd1 && room !== level_exp) begin
                $display("FAIL @%0t: room is %b, expected %b", $time, room, level_exp);
                mismatches++;
            end
            if (level_sel == 2'd2 && exception_out !== level_exp) begin
                $display("FAIL @%0t: exception_out is %b, expected %b",
                         $time, exception_out, level_exp);
                mismatches++;
            end
        end
    end

    // records still queued never showed up
    function int report();
        int missing;
        missing = exp_commit.size() + exp_alu.size() + exp_lsu.size() + exp_bru.size();
        if (missing != 0)
            $display("records expected but never seen: %0d", missing);
        $display("errors: %0d mismatches, %0d unexpected, %0d missing",
                 mismatches, unexpected, missing);
        return mismatches + unexpected + missing;
    endfunction

endmodule

// ==== rob_core.sv ====
`timescale 1ns/1ps
`include "rob_defs.svh"

module rob_core (
    input  logic                                        clk_in,
    input  logic                                        rst_N_in,
    input  logic                                        flush_in,
    input  rob_pkg::rob_entry_t [`DISPATCH_WIDTH-1:0]   dispatch_in,
    input  rob_pkg::rob_wb_t [`WB_PORTS-1:0]            wb_in,
    input  logic [`NUM_PHYS_REGS-1:0]                   scoreboard_in,
    input  logic                                        alu_ready_in,
    input  logic                                        lsu_ready_in,
    input  logic                                        bru_ready_in,
    output logic                                        room,
    output rob_pkg::rob_issue_t                         alu_issue,
    output rob_pkg::rob_issue_t                         lsu_issue,
    output rob_pkg::rob_issue_t                         bru_issue,
    output rob_pkg::rob_commit_t [1:0]                  commit_out,
    output logic                                        exception_out
);
    import rob_pkg::*;

    rob_entry_t [`ROB_ENTRIES-1:0] entries;
    logic [`ROB_PTR_BITS-1:0] head_ptr;
    logic [`ROB_PTR_BITS:0]   count;
    logic [`ROB_ENTRIES-1:0]  issue_mark;
    logic [1:0]               retire_count;

    rob_queue u_queue (
        .clk_in       (clk_in),
        .rst_N_in     (rst_N_in),
        .flush_in     (flush_in),
        .dispatch_in  (dispatch_in),
        .wb_in        (wb_in),
        .issue_mark   (issue_mark),
        .retire_count (retire_count),
        .entries      (entries),
        .head_ptr     (head_ptr),
        .count        (count),
        .room         (room)
    );

    rob_issue_select u_select (
        .clk_in        (clk_in),
        .rst_N_in      (rst_N_in),
        .flush_in      (flush_in),
        .entries       (entries),
        .head_ptr      (head_ptr),
        .count         (count),
        .scoreboard_in (scoreboard_in),
        .alu_ready_in  (alu_ready_in),
        .lsu_ready_in  (lsu_ready_in),
        .bru_ready_in  (bru_ready_in),
        .alu_issue     (alu_issue),
        .lsu_issue     (lsu_issue),
        .bru_issue     (bru_issue),
        .issue_mark    (issue_mark)
    );

    rob_commit u_commit (
        .clk_in        (clk_in),
        .rst_N_in      (rst_N_in),
        .flush_in      (flush_in),
        .entries       (entries),
        .head_ptr      (head_ptr),
        .count         (count),
        .commit_out    (commit_out),
        .retire_count  (retire_count),
        .exception_out (exception_out)
    );

endmodule

// ==== rob_commit.sv ====
`timescale 1ns/1ps
`include "rob_defs.svh"

module rob_commit (
    input  logic                                    clk_in,
    input  logic                                    rst_N_in,
    input  logic                                    flush_in,
    input  rob_pkg::rob_entry_t [`ROB_ENTRIES-1:0]  entries,
    input  logic [`ROB_PTR_BITS-1:0]                head_ptr,
    input  logic [`ROB_PTR_BITS:0]                  count,
    output rob_pkg::rob_commit_t [1:0]              commit_out,
    output logic [1:0]                              retire_count,
    output logic                                    exception_out
);
    import rob_pkg::*;

    rob_entry_t head_e, next_e;
    logic [`ROB_PTR_BITS-1:0] next_ptr;
    logic ret0, ret1, head_exc;

    assign next_ptr = head_ptr + 1'b1; // wraps with the window
    assign head_e   = entries[head_ptr];
    assign next_e   = entries[next_ptr];

    assign ret0     = (count != 0) && head_e.valid && (head_e.status == ST_DONE);
    assign ret1     = ret0 && (count > 1) && next_e.valid && (next_e.status == ST_DONE);
    assign head_exc = (count != 0) && head_e.valid && (head_e.status == ST_EXCEPTION);

    assign retire_count = {ret1, ret0 & ~ret1};

    always_ff @(posedge clk_in) begin
        if (rst_N_in || flush_in) begin
            commit_out    <= '0;
            exception_out <= 1'b0;
        end else begin
            commit_out[0] <= '{valid: ret0, arch_dest: head_e.arch_dest,
                               phys_dest: head_e.phys_dest};
            commit_out[1] <= '{valid: ret1, arch_dest: next_e.arch_dest,
                               phys_dest: next_e.phys_dest};
            if (head_exc)
                exception_out <= 1'b1; // sticky until flush
        end
    end

    // a stopped window retires nothing
    a_no_retire_on_exc: assert property (@(posedge clk_in) disable iff (rst_N_in)
        exception_out |-> retire_count == 2'd0);

endmodule

// ==== rob_issue_select.sv ====
`timescale 1ns/1ps
`include "rob_defs.svh"

module rob_issue_select (
    input  logic                                    clk_in,
    input  logic                                    rst_N_in,
    input  logic                                    flush_in,
    input  rob_pkg::rob_entry_t [`ROB_ENTRIES-1:0]  entries,
    input  logic [`ROB_PTR_BITS-1:0]                head_ptr,
    input  logic [`ROB_PTR_BITS:0]                  count,
    input  logic [`NUM_PHYS_REGS-1:0]               scoreboard_in,
    input  logic                                    alu_ready_in,
    input  logic                                    lsu_ready_in,
    input  logic                                    bru_ready_in,
    output rob_pkg::rob_issue_t                     alu_issue,
    output rob_pkg::rob_issue_t                     lsu_issue,
    output rob_pkg::rob_issue_t                     bru_issue,
    output logic [`ROB_ENTRIES-1:0]                 issue_mark
);
    import rob_pkg::*;

    localparam int PTR_W = `ROB_PTR_BITS;

    rob_issue_t alu_pick, lsu_pick, bru_pick;
    logic [`ROB_ENTRIES-1:0] alu_mask, lsu_mask, bru_mask;

    function automatic rob_issue_t to_issue(input rob_entry_t e, input logic [PTR_W-1:0] ptr);
        rob_issue_t u;
        u.valid     = 1'b1;
        u.ptr       = ptr;
        u.op        = e.op;
        u.phys_dest = e.phys_dest;
        u.phys_src1 = e.phys_src1;
        u.phys_src2 = e.phys_src2;
        return u;
    endfunction

    // oldest first, walking from head over the occupied slots
    always_comb begin
        logic [PTR_W-1:0] idx;
        rob_entry_t       e;
        logic             eligible;
        alu_pick = '0;
        lsu_pick = '0;
        bru_pick = '0;
        alu_mask = '0;
        lsu_mask = '0;
        bru_mask = '0;

        for (int k = 0; k < `ROB_ENTRIES; k++) begin
            idx      = head_ptr + PTR_W'(k);
            e        = entries[idx];
            eligible = (k < count) && e.valid && (e.status == ST_READY)
                       && scoreboard_in[e.phys_src1] && scoreboard_in[e.phys_src2];
            if (eligible) begin
                if (e.op == OP_ALU && alu_ready_in && !alu_pick.valid) begin
                    alu_pick      = to_issue(e, idx);
                    alu_mask[idx] = 1'b1;
                end
                // store goes only from the head
                if (((e.op == OP_LOAD) || (e.op == OP_STORE && k == 0))
                    && lsu_ready_in && !lsu_pick.valid) begin
                    lsu_pick      = to_issue(e, idx);
                    lsu_mask[idx] = 1'b1;
                end
                if (e.op == OP_BRANCH && bru_ready_in && !bru_pick.valid) begin
                    bru_pick      = to_issue(e, idx);
                    bru_mask[idx] = 1'b1;
                end
            end
        end
    end

    assign issue_mark = alu_mask | lsu_mask | bru_mask; // queue marks these at the edge

    always_ff @(posedge clk_in) begin
        if (rst_N_in || flush_in) begin
            alu_issue <= '0;
            lsu_issue <= '0;
            bru_issue <= '0;
        end else begin
            alu_issue <= alu_pick;
            lsu_issue <= lsu_pick;
            bru_issue <= bru_pick;
        end
    end

    // a marked slot leaves ST_READY at the edge, so it is never picked again right after
    a_single_mark: assert property (@(posedge clk_in) disable iff (rst_N_in)
        (|issue_mark) |=> ((issue_mark & $past(issue_mark)) == '0));

endmodule

// ==== rob_queue.sv ====
`timescale 1ns/1ps
`include "rob_defs.svh"

module rob_queue (
    input  logic                                        clk_in,
    input  logic                                        rst_N_in,
    input  logic                                        flush_in,
    input  rob_pkg::rob_entry_t [`DISPATCH_WIDTH-1:0]   dispatch_in,
    input  rob_pkg::rob_wb_t [`WB_PORTS-1:0]            wb_in,
    input  logic [`ROB_ENTRIES-1:0]                     issue_mark,
    input  logic [1:0]                                  retire_count,
    output rob_pkg::rob_entry_t [`ROB_ENTRIES-1:0]      entries,
    output logic [`ROB_PTR_BITS-1:0]                    head_ptr,
    output logic [`ROB_PTR_BITS:0]                      count,
    output logic                                        room
);
    import rob_pkg::*;

    localparam int PTR_W = `ROB_PTR_BITS;

    rob_entry_t [`ROB_ENTRIES-1:0] q_next;
    logic [PTR_W-1:0] tail, tail_next, head_next;
    logic [PTR_W:0]   count_next;
    logic [PTR_W:0]   n_disp; // slots taken this cycle
    logic             disp_any;

    always_comb begin
        logic [PTR_W-1:0] idx;
        q_next    = entries;
        tail_next = tail;
        n_disp    = '0;
        disp_any  = 1'b0;
        idx       = '0;

        for (int s = 0; s < `ROB_ENTRIES; s++) begin
            if (issue_mark[s])
                q_next[s].status = ST_ISSUED;
        end
        // writebacks come after marks so they win on the same slot
        for (int p = 0; p < `WB_PORTS; p++) begin
            if (wb_in[p].valid)
                q_next[wb_in[p].ptr].status = wb_in[p].exception ? ST_EXCEPTION : ST_DONE;
        end

        for (int k = 0; k < 2; k++) begin
            idx = head_ptr + PTR_W'(k);
            if (k < retire_count)
                q_next[idx].valid = 1'b0; // free retired slot
        end

        // valid micro-ops packed at the tail in offer order
        for (int d = 0; d < `DISPATCH_WIDTH; d++) begin
            if (dispatch_in[d].valid) begin
                q_next[tail_next]        = dispatch_in[d];
                q_next[tail_next].status = ST_READY;
                tail_next                = tail_next + 1'b1;
                n_disp                   = n_disp + 1'b1;
                disp_any                 = 1'b1;
            end
        end

        head_next  = head_ptr + {1'b0, retire_count};
        count_next = count + n_disp - {2'b00, retire_count};

        if (flush_in) begin
            for (int s = 0; s < `ROB_ENTRIES; s++)
                q_next[s].valid = 1'b0;
            head_next  = '0;
            tail_next  = '0; // allocation restarts at slot 0
            count_next = '0;
        end
    end

    always_ff @(posedge clk_in) begin
        if (rst_N_in) begin
            head_ptr <= '0;
            tail     <= '0;
            count    <= '0;
            for (int s = 0; s < `ROB_ENTRIES; s++)
                entries[s].valid <= 1'b0;
        end else begin
            head_ptr <= head_next;
            tail     <= tail_next;
            count    <= count_next;
            entries  <= q_next;
        end
    end

    assign room = (`ROB_ENTRIES - count) >= `DISPATCH_WIDTH;

    a_dispatch_needs_room: assert property (@(posedge clk_in) disable iff (rst_N_in)
        disp_any |-> room);

    a_count_in_range: assert property (@(posedge clk_in) disable iff (rst_N_in)
        count <= `ROB_ENTRIES);

    for (genvar p = 0; p < `WB_PORTS; p++) begin : g_wb_chk
        a_wb_to_live_slot: assert property (@(posedge clk_in) disable iff (rst_N_in)
            wb_in[p].valid |-> entries[wb_in[p].ptr].valid);
    end

endmodule

// ==== rob_pkg.sv ====
`include "rob_defs.svh"

package rob_pkg;

    // micro-op class, picks the execution unit
    typedef enum logic [1:0] {
        OP_ALU,
        OP_LOAD,
        OP_STORE,
        OP_BRANCH
    } rob_op_e;

    typedef enum logic [1:0] {
        ST_READY, // waiting for issue
        ST_ISSUED,
        ST_DONE,
        ST_EXCEPTION
    } rob_status_e;

    typedef struct packed {
        logic                               valid;
        rob_op_e                            op;
        logic [$clog2(`NUM_ARCH_REGS)-1:0]  arch_dest;
        logic [$clog2(`NUM_PHYS_REGS)-1:0]  phys_dest;
        logic [$clog2(`NUM_PHYS_REGS)-1:0]  phys_src1;
        logic [$clog2(`NUM_PHYS_REGS)-1:0]  phys_src2;
        rob_status_e                        status;
    } rob_entry_t;

    typedef struct packed {
        logic                       valid;
        logic [`ROB_PTR_BITS-1:0]   ptr; // slot that finished
        logic                       exception;
    } rob_wb_t;

    typedef struct packed {
        logic                               valid;
        logic [`ROB_PTR_BITS-1:0]           ptr;
        rob_op_e                            op;
        logic [$clog2(`NUM_PHYS_REGS)-1:0]  phys_dest;
        logic [$clog2(`NUM_PHYS_REGS)-1:0]  phys_src1;
        logic [$clog2(`NUM_PHYS_REGS)-1:0]  phys_src2;
    } rob_issue_t;

    // retirement rename table update
    typedef struct packed {
        logic                               valid;
        logic [$clog2(`NUM_ARCH_REGS)-1:0]  arch_dest;
        logic [$clog2(`NUM_PHYS_REGS)-1:0]  phys_dest;
    } rob_commit_t;

endpackage

// ==== rob_defs.svh ====
`ifndef ROB_DEFS_SVH
`define ROB_DEFS_SVH

// window geometry
`define ROB_ENTRIES 8
`define ROB_PTR_BITS 3 // log2 of ROB_ENTRIES

// front end and back end widths
`define DISPATCH_WIDTH 2 // micro-ops offered per cycle
`define WB_PORTS 2 // completion reports per cycle

// register spaces
`define NUM_PHYS_REGS 16 // one scoreboard bit each
`define NUM_ARCH_REGS 8

`endif
